// ==== Makefile ====
TOP := tb_serdes_drp
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f src.f --top-module serdes_drp_top

obj_dir/$(TOP): src.f rtl/*.sv rtl/*.svh sim/*.sv
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o $(TOP)

# A crash or a failed assertion counts as a failure too
sim: obj_dir/$(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1 || echo "TB FAILED" >> $(LOG)
	cat $(LOG)
	! grep -q "TB FAILED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== rtl/apb_drp_regs.sv ====
`timescale 1ns/1ps
`include "serdes_drp_cfg.svh"

module apb_drp_regs (
	input  logic              apb,
	input  logic              reset,
	input  apb_pkg::apb_req_t apb_req,
	output apb_pkg::apb_rsp_t apb_rsp,
	input  logic              rx_rst_done,
	output drp_pkg::drp_req_t req,
	output logic              req_valid,
	input  logic              req_ready,
	input  drp_pkg::drp_rsp_t done,
	input  logic              done_valid,
	output logic              done_ready
);
	// Access phase of any transfer
	logic access;
	// Writes to the two writable registers
	logic addr_wr;
	logic data_wr;
	// REG_ADDR write that is actually taken
	logic launch;
	// One DRP access outstanding
	logic busy;
	// Outstanding access is a read
	logic pend_read;
	// Staged write data and last read result
	logic [`SDRP_DRP_DATA_W-1:0] wdata_r;
	logic [`SDRP_DRP_DATA_W-1:0] rdata_r;

	////////////////////
	// Access decode

	// No wait states, every access phase completes at once
	assign access  = apb_req.psel && apb_req.penable;
	assign addr_wr = access && apb_req.pwrite && (apb_req.paddr == `SDRP_REG_ADDR);
	assign data_wr = access && apb_req.pwrite && (apb_req.paddr == `SDRP_REG_DATA);
	assign launch  = addr_wr && !busy;

	// Response always comes back
	assign done_ready = 1'b1;

	always_comb begin
		apb_rsp.pready  = access;
		apb_rsp.pslverr = 1'b0;
		apb_rsp.prdata  = '0;
		if (access) begin
			if (apb_req.pwrite) begin
				case (apb_req.paddr)
					// Refused while an access is in flight
					`SDRP_REG_ADDR: apb_rsp.pslverr = busy;
					`SDRP_REG_DATA: apb_rsp.pslverr = 1'b0;
					default:        apb_rsp.pslverr = 1'b1;
				endcase
			end else begin
				case (apb_req.paddr)
					// Last read result, zero extended
					`SDRP_REG_DATA: apb_rsp.prdata = `SDRP_APB_DATA_W'(rdata_r);
					// Status and its mirror
					`SDRP_REG_STATUS,
					`SDRP_REG_STATUS_2: begin
						apb_rsp.prdata = `SDRP_APB_DATA_W'({rx_rst_done, busy});
					end
					// REG_ADDR has no readback
					default: apb_rsp.pslverr = 1'b1;
				endcase
			end
		end
	end

	////////////////////
	// Payload registers

	// Low half of pwdata goes to the DRP
	always_ff @(posedge apb) begin
		if (data_wr) begin
			wdata_r <= apb_req.pwdata[`SDRP_DRP_DATA_W-1:0];
		end
	end

	// Request held until the channel takes it
	always_ff @(posedge apb) begin
		if (launch) begin
			req.we    <= apb_req.pwdata[`SDRP_WRITE_BIT];
			req.addr  <= apb_req.pwdata[`SDRP_DRP_ADDR_W-1:0];
			req.wdata <= wdata_r;
		end
	end

	////////////////////
	// Control state

	always_ff @(posedge apb) begin
		if (reset) begin
			busy      <= 1'b0;
			req_valid <= 1'b0;
			pend_read <= 1'b0;
			rdata_r   <= '0;
		end else begin
			// Request handed to the crossing
			if (req_valid && req_ready) begin
				req_valid <= 1'b0;
			end
			// Completion back from the DRP side
			if (done_valid) begin
				busy <= 1'b0;
				if (pend_read) begin
					rdata_r <= done.rdata;
				end
			end
			// New access
			if (launch) begin
				busy      <= 1'b1;
				req_valid <= 1'b1;
				pend_read <= !apb_req.pwdata[`SDRP_WRITE_BIT];
			end
		end
	end

	////////////////////
	// Checks

	// Refused REG_ADDR write must not disturb the request
	a_no_launch_busy: assert property (@(posedge apb) disable iff (reset)
		addr_wr && apb_rsp.pslverr |=> $stable(req) && !$rose(req_valid));

	// Request held until taken
	a_req_hold: assert property (@(posedge apb) disable iff (reset)
		req_valid && !req_ready |=> req_valid && $stable(req));

endmodule

// ==== rtl/apb_pkg.sv ====
`include "serdes_drp_cfg.svh"

package apb_pkg;

	////////////////////
	// Completer inputs

	// Everything the APB master drives for one transfer
	typedef struct packed {
		// Select and phase
		logic psel;
		logic penable;
		// Direction, high for a write
		logic pwrite;
		// Byte offset into the register map
		logic [`SDRP_APB_ADDR_W-1:0] paddr;
		// Write data, ignored on reads
		logic [`SDRP_APB_DATA_W-1:0] pwdata;
	} apb_req_t;

	////////////////////
	// Completer outputs

	// Everything the completer returns
	typedef struct packed {
		// Transfer done this cycle
		logic pready;
		// Refused or unmapped access
		logic pslverr;
		// Read data, zero on errors and writes
		logic [`SDRP_APB_DATA_W-1:0] prdata;
	} apb_rsp_t;

endpackage

// ==== rtl/drp_cdc_channel.sv ====
`timescale 1ns/1ps
`include "serdes_drp_cfg.svh"

module drp_cdc_channel #(
	parameter type payload_t = logic
) (
	input  logic     src_clk,
	input  logic     src_reset,
	input  payload_t src_data,
	input  logic     src_valid,
	output logic     src_ready,
	input  logic     dst_clk,
	input  logic     dst_reset,
	output payload_t dst_data,
	output logic     dst_valid,
	input  logic     dst_ready
);
	// Source side holding register and request toggle
	payload_t hold;
	logic     req_tgl;
	// Acknowledge toggle seen in the source clock
	logic [`SDRP_SYNC_STAGES-1:0] ack_sync;
	// Request toggle seen in the destination clock
	logic [`SDRP_SYNC_STAGES-1:0] req_sync;
	// Destination side acknowledge toggle
	logic     ack_tgl;
	// New crossing landed, nothing presented yet
	logic     arrive;

	////////////////////
	// Source clock

	// Idle once the acknowledge has caught up
	assign src_ready = (req_tgl == ack_sync[`SDRP_SYNC_STAGES-1]);

	// Payload frozen for the whole crossing
	always_ff @(posedge src_clk) begin
		if (src_valid && src_ready) begin
			hold <= src_data;
		end
	end

	always_ff @(posedge src_clk) begin
		if (src_reset) begin
			req_tgl  <= 1'b0;
			ack_sync <= '0;
		end else begin
			ack_sync <= {ack_sync[`SDRP_SYNC_STAGES-2:0], ack_tgl};
			if (src_valid && src_ready) begin
				req_tgl <= ~req_tgl;
			end
		end
	end

	////////////////////
	// Destination clock

	assign arrive = !dst_valid && (req_sync[`SDRP_SYNC_STAGES-1] != ack_tgl);

	// Hold is stable by the time the toggle is through
	always_ff @(posedge dst_clk) begin
		if (arrive) begin
			dst_data <= hold;
		end
	end

	always_ff @(posedge dst_clk) begin
		if (dst_reset) begin
			req_sync  <= '0;
			ack_tgl   <= 1'b0;
			dst_valid <= 1'b0;
		end else begin
			req_sync <= {req_sync[`SDRP_SYNC_STAGES-2:0], req_tgl};
			// Taken, send the acknowledge back
			if (dst_valid && dst_ready) begin
				dst_valid <= 1'b0;
				ack_tgl   <= ~ack_tgl;
			end else if (arrive) begin
				dst_valid <= 1'b1;
			end
		end
	end

	// Payload held under back-pressure
	a_dst_hold: assert property (@(posedge dst_clk) disable iff (dst_reset)
		dst_valid && !dst_ready |=> dst_valid && $stable(dst_data));

endmodule

// ==== rtl/drp_pkg.sv ====
`include "serdes_drp_cfg.svh"

package drp_pkg;

	////////////////////
	// Request payload

	// One DRP access as issued by the register stage
	typedef struct packed {
		// High for a DRP write, low for a read
		logic we;
		// Transceiver register address
		logic [`SDRP_DRP_ADDR_W-1:0] addr;
		// Write data
		// Carried on reads too, the port master ignores it there
		logic [`SDRP_DRP_DATA_W-1:0] wdata;
	} drp_req_t;

	////////////////////
	// Response payload

	// Completion of one DRP access
	typedef struct packed {
		// Value sampled from drp_do on drp_rdy
		// Meaningless after a write
		logic [`SDRP_DRP_DATA_W-1:0] rdata;
	} drp_rsp_t;

endpackage

// ==== rtl/drp_port_master.sv ====
`timescale 1ns/1ps
`include "serdes_drp_cfg.svh"

module drp_port_master (
	input  logic                        drp_clk,
	input  logic                        drp_reset_async,
	output logic                        reset_drp,
	input  drp_pkg::drp_req_t           req,
	input  logic                        req_valid,
	output logic                        req_ready,
	output drp_pkg::drp_rsp_t           rsp,
	output logic                        rsp_valid,
	input  logic                        rsp_ready,
	output logic                        drp_en,
	output logic                        drp_we,
	output logic [`SDRP_DRP_ADDR_W-1:0] drp_addr,
	output logic [`SDRP_DRP_DATA_W-1:0] drp_di,
	input  logic [`SDRP_DRP_DATA_W-1:0] drp_do,
	input  logic                        drp_rdy
);
	// Idle, access issued, response held
	typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_RESP} state_t;

	state_t state;
	// Reset chain into drp_clk
	logic [`SDRP_SYNC_STAGES-1:0] reset_pipe;

	////////////////////
	// Reset into DRP clock

	always_ff @(posedge drp_clk) begin
		reset_pipe <= {reset_pipe[`SDRP_SYNC_STAGES-2:0], drp_reset_async};
	end

	assign reset_drp = reset_pipe[`SDRP_SYNC_STAGES-1];

	////////////////////
	// Sequencer

	// One access at a time
	assign req_ready = (state == ST_IDLE);
	assign rsp_valid = (state == ST_RESP);

	always_ff @(posedge drp_clk) begin
		if (reset_drp) begin
			state  <= ST_IDLE;
			drp_en <= 1'b0;
			drp_we <= 1'b0;
		end else begin
			// Strobes last a single cycle
			drp_en <= 1'b0;
			drp_we <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (req_valid) begin
						state  <= ST_WAIT;
						drp_en <= 1'b1;
						drp_we <= req.we;
					end
				end
				// No timeout, the port always answers
				ST_WAIT: begin
					if (drp_rdy) begin
						state <= ST_RESP;
					end
				end
				ST_RESP: begin
					if (rsp_ready) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Address, write data and read result
	always_ff @(posedge drp_clk) begin
		if (state == ST_IDLE && req_valid) begin
			drp_addr <= req.addr;
			drp_di   <= req.wdata;
		end
		if (state == ST_WAIT && drp_rdy) begin
			rsp.rdata <= drp_do;
		end
	end

	// Port answers only to an issued access
	a_rdy_idle: assert property (@(posedge drp_clk) disable iff (reset_drp)
		state == ST_IDLE |-> !drp_rdy);

endmodule

// ==== rtl/serdes_drp_cfg.svh ====
`ifndef SERDES_DRP_CFG_SVH
`define SERDES_DRP_CFG_SVH

////////////////////
// Bus widths

// APB side of the bridge
`define SDRP_APB_ADDR_W 8
`define SDRP_APB_DATA_W 32

// Transceiver DRP side
`define SDRP_DRP_ADDR_W 9
`define SDRP_DRP_DATA_W 16

////////////////////
// Register map

// Offsets as seen on paddr
`define SDRP_REG_ADDR     8'h00
`define SDRP_REG_DATA     8'h20
`define SDRP_REG_STATUS   8'h40
`define SDRP_REG_STATUS_2 8'h60

// Write flag in a REG_ADDR write, set for a DRP write
`define SDRP_WRITE_BIT 15

// Flops in every synchronizer chain
`define SDRP_SYNC_STAGES 2

`endif

// ==== rtl/serdes_drp_top.sv ====
`timescale 1ns/1ps
`include "serdes_drp_cfg.svh"

module serdes_drp_top (
	input  logic                        apb,
	input  logic                        reset,
	input  apb_pkg::apb_req_t           apb_req,
	output apb_pkg::apb_rsp_t           apb_rsp,
	input  logic                        drp_clk,
	output logic                        drp_en,
	output logic                        drp_we,
	output logic [`SDRP_DRP_ADDR_W-1:0] drp_addr,
	output logic [`SDRP_DRP_DATA_W-1:0] drp_wdata,
	input  logic [`SDRP_DRP_DATA_W-1:0] drp_rdata,
	input  logic                        drp_rdy,
	input  logic                        rx_rst_done
);
	import drp_pkg::*;

	// Regs to request channel
	drp_req_t req;
	logic     req_valid;
	logic     req_ready;
	// Request channel to port master
	drp_req_t drp_req;
	logic     drp_req_valid;
	logic     drp_req_ready;
	// Port master to response channel
	drp_rsp_t rsp;
	logic     rsp_valid;
	logic     rsp_ready;
	// Response channel back to regs
	drp_rsp_t done;
	logic     done_valid;
	logic     done_ready;
	// DRP domain reset
	logic     reset_drp;

	////////////////////
	// APB clock

	apb_drp_regs u_regs (
		.apb        (apb),
		.reset      (reset),
		.apb_req    (apb_req),
		.apb_rsp    (apb_rsp),
		.rx_rst_done(rx_rst_done),
		.req        (req),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.done       (done),
		.done_valid (done_valid),
		.done_ready (done_ready)
	);

	////////////////////
	// Crossings

	// Requests into the DRP clock
	drp_cdc_channel #(.payload_t(drp_req_t)) u_req_chan (
		.src_clk  (apb),
		.src_reset(reset),
		.src_data (req),
		.src_valid(req_valid),
		.src_ready(req_ready),
		.dst_clk  (drp_clk),
		.dst_reset(reset_drp),
		.dst_data (drp_req),
		.dst_valid(drp_req_valid),
		.dst_ready(drp_req_ready)
	);

	// Responses back to the APB clock
	drp_cdc_channel #(.payload_t(drp_rsp_t)) u_rsp_chan (
		.src_clk  (drp_clk),
		.src_reset(reset_drp),
		.src_data (rsp),
		.src_valid(rsp_valid),
		.src_ready(rsp_ready),
		.dst_clk  (apb),
		.dst_reset(reset),
		.dst_data (done),
		.dst_valid(done_valid),
		.dst_ready(done_ready)
	);

	////////////////////
	// DRP clock

	drp_port_master u_master (
		.drp_clk        (drp_clk),
		.drp_reset_async(reset),
		.reset_drp      (reset_drp),
		.req            (drp_req),
		.req_valid      (drp_req_valid),
		.req_ready      (drp_req_ready),
		.rsp            (rsp),
		.rsp_valid      (rsp_valid),
		.rsp_ready      (rsp_ready),
		.drp_en         (drp_en),
		.drp_we         (drp_we),
		.drp_addr       (drp_addr),
		.drp_di         (drp_wdata),
		.drp_do         (drp_rdata),
		.drp_rdy        (drp_rdy)
	);

endmodule

// ==== sim/drp_port_model.sv ====
`timescale 1ns/1ps
`include "serdes_drp_cfg.svh"

module drp_port_model (
	input  logic                        drp_clk,
	input  logic                        drp_en,
	input  logic                        drp_we,
	input  logic [`SDRP_DRP_ADDR_W-1:0] drp_addr,
	input  logic [`SDRP_DRP_DATA_W-1:0] drp_wdata,
	output logic [`SDRP_DRP_DATA_W-1:0] drp_rdata,
	output logic                        drp_rdy
);
	// Transceiver register file
	logic [`SDRP_DRP_DATA_W-1:0] mem [0:(1<<`SDRP_DRP_ADDR_W)-1];
	// Access captured on drp_en
	logic                        cur_we;
	logic [`SDRP_DRP_ADDR_W-1:0] cur_addr;
	logic [`SDRP_DRP_DATA_W-1:0] cur_wdata;
	// Cycles left until drp_rdy
	int   delay;
	logic fire;
	int   seed;

	initial begin
		seed      = 50;
		delay     = 0;
		drp_rdy   = 1'b0;
		drp_rdata = '0;
		for (int i = 0; i < (1<<`SDRP_DRP_ADDR_W); i++) begin
			mem[i] = '0;
		end
		forever begin
			@(posedge drp_clk);
			// Strobes sampled right at the edge
			fire = 1'b0;
			if (drp_en === 1'b1) begin
				cur_we    = drp_we;
				cur_addr  = drp_addr;
				cur_wdata = drp_wdata;
				// Between 1 and 8 cycles
				delay     = 1 + ({$random(seed)} % 8);
			end
			if (delay > 0) begin
				delay = delay - 1;
				fire  = (delay == 0);
			end
			// Outputs move a little after the edge
			#1;
			drp_rdy = fire;
			if (fire) begin
				if (cur_we) begin
					mem[cur_addr] = cur_wdata;
					// Junk on drp_do, a write must not touch the read result
					drp_rdata = 16'($random(seed));
				end else begin
					drp_rdata = mem[cur_addr];
				end
			end
		end
	end

endmodule

// ==== sim/tb_checker.sv ====
`timescale 1ns/1ps
`include "serdes_drp_cfg.svh"

module tb_checker (
	input  logic              apb,
	input  logic              reset,
	input  apb_pkg::apb_req_t apb_req,
	input  apb_pkg::apb_rsp_t apb_rsp,
	input  logic              rx_rst_done,
	output int                value_errors,
	output int                other_errors
);
	// Shadow of the transceiver registers
	logic [`SDRP_DRP_DATA_W-1:0] shadow [0:(1<<`SDRP_DRP_ADDR_W)-1];
	// Staged write data and expected REG_DATA
	logic [`SDRP_DRP_DATA_W-1:0] staged;
	logic [`SDRP_DRP_DATA_W-1:0] last_read;
	// Access launched, not yet seen idle
	logic  busy;
	string test_name;

	task automatic begin_test(input string name);
		test_name = name;
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			value_errors++;
			$display("FAIL %s %s: expected %h actual %h", test_name, what, expected, actual);
		end
	endtask

	////////////////////
	// Write model

	task automatic write_access();
		logic [`SDRP_DRP_ADDR_W-1:0] addr;
		logic                        err;
		addr = apb_req.pwdata[`SDRP_DRP_ADDR_W-1:0];
		err  = 1'b1;
		case (apb_req.paddr)
			`SDRP_REG_DATA: begin
				err    = 1'b0;
				staged = apb_req.pwdata[`SDRP_DRP_DATA_W-1:0];
			end
			// Refused while busy, otherwise starts the access
			`SDRP_REG_ADDR: begin
				err = busy;
				if (!busy) begin
					busy = 1'b1;
					if (apb_req.pwdata[`SDRP_WRITE_BIT]) begin
						shadow[addr] = staged;
					end else begin
						last_read = shadow[addr];
					end
				end
			end
			default: err = 1'b1;
		endcase
		check_value("write pslverr", 32'(err), 32'(apb_rsp.pslverr));
		check_value("write prdata", 32'h0, apb_rsp.prdata);
	endtask

	////////////////////
	// Read model

	task automatic read_access();
		logic err;
		err = 1'b0;
		case (apb_req.paddr)
			`SDRP_REG_DATA: begin
				// Result undefined until the access is over
				if (!busy) begin
					check_value("data prdata", 32'(last_read), apb_rsp.prdata);
				end
			end
			`SDRP_REG_STATUS,
			`SDRP_REG_STATUS_2: begin
				// Bit 1 and up always known
				check_value("status upper", 32'(rx_rst_done), 32'(apb_rsp.prdata[31:1]));
				// Either busy value is fine mid access
				if (!busy) begin
					check_value("status busy", 32'h0, 32'(apb_rsp.prdata[0]));
				end else if (!apb_rsp.prdata[0]) begin
					busy = 1'b0;
				end
			end
			default: begin
				err = 1'b1;
				check_value("error prdata", 32'h0, apb_rsp.prdata);
			end
		endcase
		check_value("read pslverr", 32'(err), 32'(apb_rsp.pslverr));
	endtask

	////////////////////
	// Access monitor

	initial begin
		value_errors = 0;
		other_errors = 0;
		for (int i = 0; i < (1<<`SDRP_DRP_ADDR_W); i++) begin
			shadow[i] = '0;
		end
		forever begin
			// Mid cycle, everything settled
			@(negedge apb);
			if (reset) begin
				busy      = 1'b0;
				last_read = '0;
			end else if (apb_req.psel && apb_req.penable) begin
				if (apb_rsp.pready !== 1'b1) begin
					other_errors++;
					$display("%s: access phase at %0t ns without pready", test_name, $time);
				end
				if (apb_req.pwrite) begin
					write_access();
				end else begin
					read_access();
				end
			end
		end
	end

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
	output logic apb,
	output logic drp_clk,
	output logic reset
);
	// Register side, 4 ns period
	initial begin
		apb = 1'b0;
		forever #2 apb = ~apb;
	end

	// Transceiver side, 6 ns period and offset from apb
	initial begin
		drp_clk = 1'b0;
		#1;
		forever #3 drp_clk = ~drp_clk;
	end

	// Ten apb cycles, released just after an edge
	initial begin
		reset = 1'b1;
		repeat (10) @(posedge apb);
		#1;
		reset = 1'b0;
	end

endmodule

// ==== sim/tb_serdes_drp.sv ====
`timescale 1ns/1ps
`include "serdes_drp_cfg.svh"

module tb_serdes_drp;
	import apb_pkg::*;

	localparam int NUM_RANDOM = 300;
	// Directed accesses on top of the random loop
	localparam int NUM_OPS    = NUM_RANDOM + 40;
	localparam int POLL_LIMIT = 200;

	logic     apb;
	logic     drp_clk;
	logic     reset;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	logic     rx_rst_done;
	// DRP port
	logic                        drp_en;
	logic                        drp_we;
	logic [`SDRP_DRP_ADDR_W-1:0] drp_addr;
	logic [`SDRP_DRP_DATA_W-1:0] drp_wdata;
	logic [`SDRP_DRP_DATA_W-1:0] drp_rdata;
	logic                        drp_rdy;
	// Error counts
	int value_errors;
	int other_errors;
	int stall_errors;
	int seed;

	tb_clock_gen u_clk (
		.apb    (apb),
		.drp_clk(drp_clk),
		.reset  (reset)
	);

	serdes_drp_top DUT (
		.apb        (apb),
		.reset      (reset),
		.apb_req    (apb_req),
		.apb_rsp    (apb_rsp),
		.drp_clk    (drp_clk),
		.drp_en     (drp_en),
		.drp_we     (drp_we),
		.drp_addr   (drp_addr),
		.drp_wdata  (drp_wdata),
		.drp_rdata  (drp_rdata),
		.drp_rdy    (drp_rdy),
		.rx_rst_done(rx_rst_done)
	);

	drp_port_model u_port (
		.drp_clk  (drp_clk),
		.drp_en   (drp_en),
		.drp_we   (drp_we),
		.drp_addr (drp_addr),
		.drp_wdata(drp_wdata),
		.drp_rdata(drp_rdata),
		.drp_rdy  (drp_rdy)
	);

	tb_checker u_checker (
		.apb         (apb),
		.reset       (reset),
		.apb_req     (apb_req),
		.apb_rsp     (apb_rsp),
		.rx_rst_done (rx_rst_done),
		.value_errors(value_errors),
		.other_errors(other_errors)
	);

	////////////////////
	// APB master

	// Setup then access phase, no wait states
	task automatic apb_transfer(input logic write, input logic [`SDRP_APB_ADDR_W-1:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		@(posedge apb);
		#1;
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = write;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(posedge apb);
		#1;
		apb_req.penable = 1'b1;
		@(negedge apb);
		rdata = apb_rsp.prdata;
		@(posedge apb);
		#1;
		apb_req.psel    = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	task automatic apb_write(input logic [`SDRP_APB_ADDR_W-1:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		apb_transfer(1'b1, addr, data, unused);
	endtask

	task automatic apb_read(input logic [`SDRP_APB_ADDR_W-1:0] addr, output logic [31:0] data);
		apb_transfer(1'b0, addr, 32'h0, data);
	endtask

	// Poll REG_STATUS until bit 0 drops
	task automatic wait_idle();
		logic [31:0] status;
		int          polls;
		status = 32'h1;
		polls  = 0;
		while (status[0] && polls < POLL_LIMIT) begin
			apb_read(`SDRP_REG_STATUS, status);
			polls++;
		end
		if (status[0]) begin
			stall_errors++;
			$display("DRP access still busy after %0d status polls", polls);
		end
	endtask

	////////////////////
	// DRP accesses

	task automatic drp_write(input logic [`SDRP_DRP_ADDR_W-1:0] addr, input logic [15:0] data);
		apb_write(`SDRP_REG_DATA, 32'(data));
		apb_write(`SDRP_REG_ADDR, 32'(addr) | 32'h8000);
		wait_idle();
	endtask

	// Result checked by the checker on the REG_DATA read
	task automatic drp_read(input logic [`SDRP_DRP_ADDR_W-1:0] addr);
		logic [31:0] data;
		apb_write(`SDRP_REG_ADDR, 32'(addr));
		wait_idle();
		apb_read(`SDRP_REG_DATA, data);
	endtask

	////////////////////
	// Watchdog

	initial begin
		#(NUM_OPS * 200 + 1000);
		$display("Watchdog expired, test %s did not finish in time", u_checker.test_name);
		$display("TB FAILED");
		$finish;
	end

	////////////////////
	// Tests

	initial begin
		logic [31:0]                 rd;
		logic [31:0]                 rnd;
		logic [31:0]                 data;
		logic [31:0]                 cmd;
		logic [`SDRP_DRP_ADDR_W-1:0] addr;
		seed         = 50;
		stall_errors = 0;
		apb_req      = '0;
		rx_rst_done  = 1'b0;
		@(negedge reset);

		u_checker.begin_test("reset_values");
		apb_read(`SDRP_REG_STATUS, rd);
		apb_read(`SDRP_REG_DATA, rd);

		u_checker.begin_test("write_then_read");
		drp_write(9'h0a5, 16'h1234);
		drp_read(9'h0a5);

		// Status bit 1 and the mirror register
		u_checker.begin_test("rx_rst_done");
		apb_read(`SDRP_REG_STATUS_2, rd);
		@(posedge apb);
		#1;
		rx_rst_done = 1'b1;
		apb_read(`SDRP_REG_STATUS, rd);
		apb_read(`SDRP_REG_STATUS_2, rd);
		@(posedge apb);
		#1;
		rx_rst_done = 1'b0;
		apb_read(`SDRP_REG_STATUS, rd);

		u_checker.begin_test("errors");
		apb_write(8'h10, 32'h1);
		apb_read(8'h10, rd);
		apb_write(`SDRP_REG_STATUS, 32'h3);
		apb_read(8'h84, rd);
		apb_read(`SDRP_REG_ADDR, rd);
		// Second launch arrives while the first is in flight
		apb_write(`SDRP_REG_DATA, 32'h0000_a5a5);
		apb_write(`SDRP_REG_ADDR, 32'h8033);
		apb_write(`SDRP_REG_ADDR, 32'h8034);
		wait_idle();
		drp_read(9'h034);
		drp_read(9'h033);

		u_checker.begin_test("random");
		for (int i = 0; i < NUM_RANDOM; i++) begin
			rnd  = $random(seed);
			data = $random(seed);
			cmd  = $random(seed);
			// Half the time a small window, so reads hit written words
			addr = rnd[9] ? rnd[8:0] : {5'd0, rnd[3:0]};
			cmd[`SDRP_WRITE_BIT]           = rnd[20];
			cmd[`SDRP_DRP_ADDR_W-1:0]      = addr;
			if (rnd[20]) begin
				apb_write(`SDRP_REG_DATA, data);
			end
			apb_write(`SDRP_REG_ADDR, cmd);
			wait_idle();
			// Writes leave the last read result alone
			if (!rnd[20] || rnd[21]) begin
				apb_read(`SDRP_REG_DATA, rd);
			end
		end

		$display("Errors: %0d value, %0d other, %0d stalled",
			value_errors, other_errors, stall_errors);
		if (value_errors + other_errors + stall_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+rtl
rtl/apb_pkg.sv
rtl/drp_pkg.sv
rtl/apb_drp_regs.sv
rtl/drp_cdc_channel.sv
rtl/drp_port_master.sv
rtl/serdes_drp_top.sv
sim/tb_clock_gen.sv
sim/drp_port_model.sv
sim/tb_checker.sv
sim/tb_serdes_drp.sv
